//--- tb.f
+incdir+verilog
verilog/mem_port_pkg.sv
verilog/fetch_buffer_pkg.sv
verilog/fetch_buffer_store.sv
verilog/fetch_buffer_ctrl.sv
verilog/fetch_buffer.sv
testbench/imem_model.sv
testbench/tb_fetch_buffer.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_fetch_buffer

out=$(./obj_dir/Vtb_fetch_buffer || true)
echo "$out"

echo "$out" | grep -q "=== PASS ==="

//--- testbench/tb_fetch_buffer.sv
`timescale 1ns/1ns

`include "fetch_macros.svh"

module tb_fetch_buffer
  import mem_port_pkg::*;
();

  localparam int timeout_cycles = 4000;

  logic        clock = 1'b0;
  logic        reset;
  logic        req_valid;
  word_addr_t  req_addr;
  logic        req_fence;
  logic        req_spec;
  priv_mode_t  req_mode;
  logic        resp_ready;
  instr_word_t resp_rdata;
  logic        resp_error;
  logic        imem_valid;
  word_addr_t  imem_addr;
  priv_mode_t  imem_mode;
  logic        imem_ready;
  instr_word_t imem_rdata;
  logic        imem_error;
  int          cycles = 0;

  fetch_buffer dut_i (.*);

  imem_model mem_i (
    .clock (clock),
    .reset (reset),
    .valid (imem_valid),
    .addr  (imem_addr),
    .ready (imem_ready),
    .rdata (imem_rdata),
    .error (imem_error)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      fail_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_instr(input string name, input instr_word_t act, input instr_word_t exp);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input word_addr_t act, input word_addr_t exp);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_mode(input string name, input priv_mode_t act, input priv_mode_t exp);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // instruction at a halfword address, taken from the memory image.
  function automatic instr_word_t expected_instr(input word_addr_t pc);
    word_addr_t  nxt;
    instr_word_t lo;
    instr_word_t hi;
    logic [15:0] half;
    nxt = pc + 32'd4;
    lo = mem_i.words[pc[9:2]];
    hi = mem_i.words[nxt[9:2]];
    half = pc[1] ? lo[31:16] : lo[15:0];
    if (half[1:0] != 2'b11) begin
      return {16'h0000, half};
    end
    if (!pc[1]) begin
      return lo;
    end
    return {hi[15:0], half};
  endfunction

  function automatic logic expected_error(input word_addr_t pc);
    logic spans;
    spans = pc[1] && mem_i.words[pc[9:2]][17:16] == 2'b11;
    return mem_i.is_marked(pc) || (spans && mem_i.is_marked(pc + 32'd4));
  endfunction

  // random words with some bits forced, over a run of word indices.
  task automatic set_region(input int first, input int n, input instr_word_t keep,
                            input instr_word_t force_bits);
    for (int i = first; i < first + n; i++) begin
      mem_i.rewrite_word(i, ($urandom & keep) | force_bits);
    end
  endtask

  // called on a falling edge; returns on the falling edge after the hit.
  task automatic fetch_and_check(input word_addr_t pc, output word_addr_t next_pc);
    instr_word_t exp;
    req_valid = 1'b1;
    req_addr = pc;
    #1;
    while (!resp_ready) begin
      @(negedge clock);
      #1;
    end
    exp = expected_instr(pc);
    if (expected_error(pc)) begin
      check_flag("resp_error", resp_error, 1'b1);
    end else begin
      check_instr("resp_rdata", resp_rdata, exp);
      check_flag("resp_error", resp_error, 1'b0);
    end
    next_pc = pc + (exp[1:0] == 2'b11 ? 32'd4 : 32'd2);
    @(negedge clock);
  endtask

  task automatic run_stream(input word_addr_t start, input int n);
    word_addr_t pc;
    pc = start;
    repeat (n) begin
      fetch_and_check(pc, pc);
    end
    req_valid = 1'b0;
  endtask

  task automatic redirect_to(input word_addr_t target, input priv_mode_t mode);
    req_valid = 1'b0;
    req_spec = 1'b1;
    req_addr = target;
    req_mode = mode;
    #1;
    while (imem_valid && !imem_ready) begin // pending word finishes first.
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    req_spec = 1'b0;
    #1;
    check_flag("imem_valid", imem_valid, 1'b1);
    check_addr("imem_addr", imem_addr, {target[31:2], 2'b00});
    check_mode("imem_mode", imem_mode, mode);
    @(negedge clock);
  endtask

  task automatic fence_and_wait(input word_addr_t next_pc);
    req_valid = 1'b0;
    req_fence = 1'b1;
    #1;
    while (imem_valid && !imem_ready) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    req_fence = 1'b0;
    req_valid = 1'b1; // a lookup during the flush must not be answered.
    req_addr = next_pc;
    repeat (`FB_DEPTH + 1) begin
      #1;
      check_flag("imem_valid", imem_valid, 1'b0);
      check_flag("resp_ready", resp_ready, 1'b0);
      @(negedge clock);
    end
  endtask

  task automatic test_aligned();
    set_region(0, 12, 32'hffff_ffff, 32'h0000_0003);
    redirect_to(32'h0000_0000, 2'b11);
    run_stream(32'h0000_0000, 12);
  endtask

  task automatic test_compressed();
    set_region(32, 8, 32'hfffc_fffc, 32'h0001_0000); // both halves compressed.
    redirect_to(32'h0000_0080, 2'b11);
    run_stream(32'h0000_0080, 16);
  endtask

  task automatic test_spanning();
    set_region(64, 1, 32'hfffc_fffc, 32'h0003_0000);
    set_region(65, 11, 32'hffff_ffff, 32'h0003_0000); // every upper half starts a word.
    redirect_to(32'h0000_0100, 2'b11);
    run_stream(32'h0000_0100, 10);
  endtask

  task automatic test_errors();
    set_region(124, 16, 32'hffff_ffff, 32'h0000_0003);
    mem_i.mark_errors(32'h0000_0200, 32'h0000_021f);
    redirect_to(32'h0000_01f0, 2'b11);
    run_stream(32'h0000_01f0, 16);
  endtask

  task automatic test_redirect();
    redirect_to(32'h0000_0302, 2'b01);
    run_stream(32'h0000_0302, 10);
  endtask

  task automatic test_fence();
    set_region(224, 8, 32'hffff_ffff, 32'h0000_0003);
    redirect_to(32'h0000_0380, 2'b11);
    run_stream(32'h0000_0380, 8);
    set_region(224, 8, 32'hffff_ffff, 32'h0000_0003); // new contents.
    fence_and_wait(32'h0000_0380);
    run_stream(32'h0000_0380, 8);
  endtask

  initial begin
    void'($urandom(32'h2e43_5254));
    mem_i.fill_random();
    reset = 1'b0;
    req_valid = 1'b0;
    req_addr = '0;
    req_fence = 1'b0;
    req_spec = 1'b0;
    req_mode = 2'b11;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    repeat (2) @(negedge clock);
    test_aligned();
    test_compressed();
    test_spanning();
    test_errors();
    test_redirect();
    test_fence();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- testbench/imem_model.sv
`timescale 1ns/1ns

module imem_model
  import mem_port_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        valid,
  input  word_addr_t  addr,
  output logic        ready,
  output instr_word_t rdata,
  output logic        error
);

  localparam int words_n = 256; // 1 KiB, addresses wrap.

  instr_word_t words [0:words_n-1];
  word_addr_t  mark_lo = 32'hffff_ffff; // empty error range.
  word_addr_t  mark_hi = 32'h0000_0000;
  logic [1:0]  delay;

  // a word is handed over once its delay has run out.
  assign ready = valid && delay == 2'd0;
  assign rdata = words[addr[9:2]];
  assign error = is_marked(addr);

  always_ff @(posedge clock) begin
    if (!reset) begin
      delay <= 2'd0;
    end else if (ready) begin
      delay <= 2'($urandom_range(3, 0)); // delay for the next word.
    end else if (delay != 2'd0) begin
      delay <= delay - 2'd1;
    end
  end

  function automatic logic is_marked(input word_addr_t a);
    word_addr_t w;
    w = {a[31:2], 2'b00};
    return w >= mark_lo && w <= mark_hi;
  endfunction

  task automatic fill_random();
    for (int i = 0; i < words_n; i++) begin
      words[i] = $urandom;
    end
  endtask

  task automatic rewrite_word(input int index, input instr_word_t data);
    words[index] = data;
  endtask

  task automatic mark_errors(input word_addr_t lo, input word_addr_t hi);
    mark_lo = lo;
    mark_hi = hi;
  endtask

endmodule

//--- verilog/fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer
  import mem_port_pkg::*;
  import fetch_buffer_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  word_addr_t  req_addr,
  input  logic        req_fence,
  input  logic        req_spec,
  input  priv_mode_t  req_mode,
  output logic        resp_ready,
  output instr_word_t resp_rdata,
  output logic        resp_error,
  output logic        imem_valid,
  output word_addr_t  imem_addr,
  output priv_mode_t  imem_mode,
  input  logic        imem_ready,
  input  instr_word_t imem_rdata,
  input  logic        imem_error
);

  logic      wen;
  fb_index_t waddr;
  fb_entry_t wdata;
  fb_index_t raddr1;
  fb_index_t raddr2;
  fb_entry_t rdata1;
  fb_entry_t rdata2;

  fetch_buffer_ctrl ctrl_i (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_fence  (req_fence),
    .req_spec   (req_spec),
    .req_mode   (req_mode),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .resp_error (resp_error),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .imem_mode  (imem_mode),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .imem_error (imem_error),
    .wen        (wen),
    .waddr      (waddr),
    .wdata      (wdata),
    .raddr1     (raddr1),
    .raddr2     (raddr2),
    .rdata1     (rdata1),
    .rdata2     (rdata2)
  );

  fetch_buffer_store store_i (
    .clock  (clock),
    .wen    (wen),
    .waddr  (waddr),
    .wdata  (wdata),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

endmodule

//--- verilog/fetch_buffer_ctrl.sv
`timescale 1ns/1ns

`include "fetch_macros.svh"

module fetch_buffer_ctrl
  import mem_port_pkg::*;
  import fetch_buffer_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        req_valid,
  input  word_addr_t  req_addr,
  input  logic        req_fence,
  input  logic        req_spec,
  input  priv_mode_t  req_mode,
  output logic        resp_ready,
  output instr_word_t resp_rdata,
  output logic        resp_error,
  output logic        imem_valid,
  output word_addr_t  imem_addr,
  output priv_mode_t  imem_mode,
  input  logic        imem_ready,
  input  instr_word_t imem_rdata,
  input  logic        imem_error,
  output logic        wen,
  output fb_index_t   waddr,
  output fb_entry_t   wdata,
  output fb_index_t   raddr1,
  output fb_index_t   raddr2,
  input  fb_entry_t   rdata1,
  input  fb_entry_t   rdata2
);

  fb_state_t  state;
  fb_state_t  state_next;
  fb_count_t  count;
  fb_count_t  count_next;
  fb_count_t  count_fill;
  fb_count_t  step;
  fb_index_t  flush_idx;
  fb_index_t  flush_idx_next;
  logic       restart;      // next lookup address seeds the prefetch.
  logic       restart_next;
  logic       valid_next;
  word_addr_t addr_next;
  priv_mode_t mode_next;

  logic       ctl_fence;
  word_addr_t ctl_addr;
  priv_mode_t ctl_mode;

  word_addr_t next_addr;
  logic       lookup;
  logic       new_ctrl;
  logic       ctrl_pending;
  logic       ctrl_go;
  logic       ctrl_fence_now;
  word_addr_t ctrl_target;
  priv_mode_t ctrl_mode_now;
  logic       fill;
  fb_entry_t  fill_entry;
  logic       fwd1;
  logic       fwd2;
  fb_entry_t  ent1;
  fb_entry_t  ent2;
  logic       have1;
  logic       have2;
  logic       compressed;

  assign next_addr = req_addr + 32'd4;
  assign raddr1 = req_addr[`FB_INDEX_W+1:2];
  assign raddr2 = next_addr[`FB_INDEX_W+1:2];

  assign lookup = state == active && req_valid && !(req_fence || req_spec);
  assign new_ctrl = state == active && (req_fence || req_spec);
  assign ctrl_pending = new_ctrl || state == control;
  // an outstanding word has to come back before the address may change.
  assign ctrl_go = ctrl_pending && (!imem_valid || imem_ready);
  assign ctrl_fence_now = new_ctrl ? req_fence : ctl_fence;
  assign ctrl_target = new_ctrl ? req_addr : ctl_addr;
  assign ctrl_mode_now = new_ctrl ? req_mode : ctl_mode;

  assign fill = state == active && !new_ctrl && imem_valid && imem_ready;
  assign fill_entry = '{
    error: imem_error,
    valid: 1'b1,
    tag:   imem_addr[31:2],
    data:  imem_rdata
  };

  always_comb begin
    if (state == flush) begin
      wen = 1'b1;
      waddr = flush_idx;
      wdata = '0;
    end else begin
      wen = fill;
      waddr = imem_addr[`FB_INDEX_W+1:2];
      wdata = fill_entry;
    end
  end

  // a word arriving this cycle wins over the stored entry.
  assign fwd1 = fill && fill_entry.tag == req_addr[31:2];
  assign fwd2 = fill && fill_entry.tag == next_addr[31:2];
  assign ent1 = fwd1 ? fill_entry : rdata1;
  assign ent2 = fwd2 ? fill_entry : rdata2;
  assign have1 = ent1.valid && ent1.tag == req_addr[31:2];
  assign have2 = ent2.valid && ent2.tag == next_addr[31:2];

  always_comb begin
    resp_rdata = '0;
    resp_error = 1'b0;
    resp_ready = 1'b0;
    if (!req_addr[1]) begin
      resp_rdata = ent1.data;
      resp_error = ent1.error;
      resp_ready = lookup && have1;
    end else begin
      resp_rdata[15:0] = ent1.data[31:16];
      if (resp_rdata[1:0] != 2'b11) begin
        resp_error = ent1.error;
        resp_ready = lookup && have1;
      end else begin
        // upper half comes from the next word.
        resp_rdata[31:16] = ent2.data[15:0];
        resp_error = ent1.error || ent2.error;
        resp_ready = lookup && have1 && have2;
      end
    end
    if (resp_rdata[1:0] != 2'b11) begin
      resp_rdata[31:16] = '0; // compressed, zero extended.
    end
  end

  assign compressed = resp_rdata[1:0] != 2'b11;

  always_comb begin
    state_next = state;
    count_next = count;
    flush_idx_next = flush_idx;
    restart_next = restart;
    valid_next = imem_valid;
    addr_next = imem_addr;
    mode_next = imem_mode;
    step = compressed ? fb_count_t'(1) : fb_count_t'(2);
    count_fill = fill ? count + fb_count_t'(2) : count;
    if (ctrl_pending) begin
      if (!ctrl_go) begin
        state_next = control;
      end else if (ctrl_fence_now) begin
        state_next = flush;
        flush_idx_next = '0;
        valid_next = 1'b0;
      end else begin
        state_next = active;
        restart_next = 1'b0;
        addr_next = {ctrl_target[31:2], 2'b00};
        mode_next = ctrl_mode_now;
        count_next = '0;
        valid_next = 1'b1;
      end
    end else begin
      case (state)
        idle: begin
          state_next = active;
        end
        active: begin
          if (resp_ready && step <= count_fill) begin
            count_next = count_fill - step;
          end else begin
            count_next = count_fill;
          end
          if (fill) begin
            addr_next = imem_addr + 32'd4;
          end
          if (restart && lookup) begin
            restart_next = 1'b0;
            addr_next = {req_addr[31:2], 2'b00};
            mode_next = req_mode;
            count_next = '0;
          end
          valid_next = !restart_next && count_next < fb_count_t'(`FB_LIMIT);
        end
        flush: begin
          flush_idx_next = flush_idx + fb_index_t'(1);
          if (flush_idx == fb_index_t'(`FB_DEPTH - 1)) begin
            state_next = active;
            restart_next = 1'b1;
            count_next = '0;
          end
        end
        default: begin
          state_next = state;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
      count <= '0;
      flush_idx <= '0;
      restart <= 1'b1;
      ctl_fence <= 1'b0;
      imem_valid <= 1'b0;
      imem_addr <= '0;
      imem_mode <= machine_mode;
    end else begin
      state <= state_next;
      count <= count_next;
      flush_idx <= flush_idx_next;
      restart <= restart_next;
      imem_valid <= valid_next;
      imem_addr <= addr_next;
      imem_mode <= mode_next;
      if (new_ctrl) begin
        ctl_fence <= req_fence;
      end
    end
  end

  // target of a redirect that has to wait for the memory.
  always_ff @(posedge clock) begin
    if (new_ctrl) begin
      ctl_addr <= req_addr;
      ctl_mode <= req_mode;
    end
  end

endmodule

//--- verilog/fetch_buffer_store.sv
`timescale 1ns/1ns

`include "fetch_macros.svh"

module fetch_buffer_store
  import fetch_buffer_pkg::*;
(
  input  logic      clock,
  input  logic      wen,
  input  fb_index_t waddr,
  input  fb_entry_t wdata,
  input  fb_index_t raddr1,
  input  fb_index_t raddr2,
  output fb_entry_t rdata1,
  output fb_entry_t rdata2
);

  fb_entry_t entries [0:`FB_DEPTH-1] = '{default: '0};

  // current word and the following word for spanning instructions.
  assign rdata1 = entries[raddr1];
  assign rdata2 = entries[raddr2];

  always_ff @(posedge clock) begin
    if (wen) begin
      entries[waddr] <= wdata;
    end
  end

endmodule

//--- verilog/fetch_buffer_pkg.sv
`include "fetch_macros.svh"

package fetch_buffer_pkg;
  import mem_port_pkg::*;

  // one buffer entry, 64 bits.
  typedef struct packed {
    logic        error;
    logic        valid;
    logic [29:0] tag;   // word address, byte address bits 31..2.
    instr_word_t data;
  } fb_entry_t;

  typedef logic [`FB_INDEX_W-1:0] fb_index_t;

  // halfwords fetched ahead of the core, two extra bits of headroom.
  typedef logic [`FB_INDEX_W+1:0] fb_count_t;

  typedef enum logic [1:0] {
    idle,
    active,
    control, // waiting for the memory before a redirect or fence.
    flush
  } fb_state_t;

endpackage

//--- verilog/mem_port_pkg.sv
package mem_port_pkg;

  // privilege mode sent along with every fetch.
  typedef logic [1:0] priv_mode_t;

  typedef logic [31:0] word_addr_t; // byte address.
  typedef logic [31:0] instr_word_t;

  // mode used for fetches until the first redirect.
  localparam priv_mode_t machine_mode = 2'b11;

endpackage

//--- verilog/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// number of buffer entries, one 32-bit word each.
`define FB_DEPTH 8

// entry index width, log2 of the depth.
`define FB_INDEX_W 3

// prefetch stops while the halfword count is at or above this.
`define FB_LIMIT (2 * `FB_DEPTH - 2)

`endif
